// ==== common/mcu_bus_if.sv ====
`timescale 1ns/1ps

interface mcu_bus_if;

	logic                       req;        // one cycle strobe
	logic                       wr;
	logic [mcu_pkg::addr_w-1:0] addr;
	logic [mcu_pkg::data_w-1:0] wdata;
	mcu_pkg::region_e           region;     // target picked by the decoder

	logic [mcu_pkg::data_w-1:0] regs_rdata;
	logic [mcu_pkg::data_w-1:0] ram_rdata;

	modport decoder (
		output req, wr, addr, wdata, region,
		input  regs_rdata, ram_rdata
	);

	modport regs (
		input  req, wr, addr, wdata, region,
		output regs_rdata
	);

	modport ram (
		input  req, wr, addr, wdata, region,
		output ram_rdata
	);

endinterface

// ==== common/mcu_pkg.sv ====
package mcu_pkg;

	localparam int data_w     = 32;
	localparam int addr_w     = 32;
	localparam int ram_addr_w = 8;     // 256 words of scratch

	localparam logic [addr_w-9:0] reg_page     = '1;    // 0xFFFFFF00 page
	localparam logic [7:0]        scratch_page = 8'h01; // 0x01xxxxxx

	typedef enum logic [1:0] {
		region_scratch = 2'd0,
		region_regs    = 2'd1,
		region_none    = 2'd2
	} region_e;

	// Register page offsets
	typedef enum logic [7:0] {
		off_mailbox0         = 8'h00,
		off_mailbox1         = 8'h04,
		off_mailbox2         = 8'h08,
		off_mailbox3         = 8'h0C,
		off_mailbox4         = 8'h10,
		off_mailbox5         = 8'h14,
		off_mailbox6         = 8'h18,
		off_mailbox7         = 8'h1C,
		off_cont_key         = 8'h20,
		off_cont_joy         = 8'h30,
		off_core_input       = 8'h50,
		off_core_output      = 8'h54,
		off_slot_id          = 8'h80,
		off_bridge_addr      = 8'h84,
		off_length           = 8'h88,
		off_slot_offset      = 8'h8C,
		off_slot_cmd         = 8'h90,  // command on write, status on read
		off_tick_div         = 8'h98,
		off_slot_offset_high = 8'h9C,
		off_timer1_count     = 8'hC4,
		off_timer1_thresh    = 8'hC8,
		off_timer2_count     = 8'hCC,
		off_irq_mask         = 8'hF4,
		off_timer1_cycles    = 8'hF8,
		off_timer2_cycles    = 8'hFC
	} reg_off_e;

	// Bit positions in the command word
	typedef enum logic [2:0] {
		slot_bit_read         = 3'd0,
		slot_bit_write        = 3'd1,
		slot_bit_lba48        = 3'd2,
		slot_bit_flush        = 3'd3,
		slot_bit_get_filename = 3'd4,
		slot_bit_open_file    = 3'd5,
		slot_bit_irq_en       = 3'd6
	} slot_cmd_bit_e;

endpackage

// ==== design/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	input  logic                       bus_req,
	input  logic                       bus_wr,
	input  logic [mcu_pkg::addr_w-1:0] bus_addr,
	input  logic [mcu_pkg::data_w-1:0] bus_wdata,
	output logic [mcu_pkg::data_w-1:0] bus_rdata,
	output logic                       bus_rsp_valid,
	mcu_bus_if.decoder                 bus
);

	mcu_pkg::region_e region_d;
	mcu_pkg::region_e rsp_region;   // target of the request in flight
	logic             rsp_wr;

	always_comb begin
		if (bus_addr[mcu_pkg::addr_w-1:8] == mcu_pkg::reg_page)
			region_d = mcu_pkg::region_regs;
		else if (bus_addr[mcu_pkg::addr_w-1:mcu_pkg::addr_w-8] == mcu_pkg::scratch_page)
			region_d = mcu_pkg::region_scratch;
		else
			region_d = mcu_pkg::region_none;
	end

	// Request goes to every peripheral, region says who takes it
	assign bus.req    = bus_req;
	assign bus.wr     = bus_wr;
	assign bus.addr   = bus_addr;
	assign bus.wdata  = bus_wdata;
	assign bus.region = region_d;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			bus_rsp_valid <= 1'b0;
			rsp_region    <= mcu_pkg::region_none;
			rsp_wr        <= 1'b0;
		end else begin
			bus_rsp_valid <= bus_req && (region_d != mcu_pkg::region_none); // unmapped stays silent
			if (bus_req) begin
				rsp_region <= region_d;
				rsp_wr     <= bus_wr;
			end
		end
	end

	// Response data in the cycle after the request
	always_comb begin
		bus_rdata = '0;
		if (!rsp_wr) begin
			case (rsp_region)
				mcu_pkg::region_scratch: bus_rdata = bus.ram_rdata;
				mcu_pkg::region_regs:    bus_rdata = bus.regs_rdata;
				default:                 bus_rdata = '0;
			endcase
		end
	end

endmodule

// ==== design/mcu_periph_top.sv ====
`timescale 1ns/1ps

module mcu_periph_top (
	input  logic                       clk_sys,
	input  logic                       reset_n,

	input  logic                       bus_req,
	input  logic                       bus_wr,
	input  logic [mcu_pkg::addr_w-1:0] bus_addr,
	input  logic [mcu_pkg::data_w-1:0] bus_wdata,
	output logic [mcu_pkg::data_w-1:0] bus_rdata,
	output logic                       bus_rsp_valid,

	input  logic [mcu_pkg::data_w-1:0] cont_key,
	input  logic [mcu_pkg::data_w-1:0] cont_joy,
	input  logic [mcu_pkg::data_w-1:0] core_input,
	output logic [mcu_pkg::data_w-1:0] core_output,

	output logic                       slot_read,
	output logic                       slot_write,
	output logic                       slot_flush,
	output logic                       slot_get_filename,
	output logic                       slot_open_file,
	output logic                       slot_lba48,
	input  logic                       slot_ack,
	input  logic                       slot_done,
	input  logic [5:0]                 slot_err,
	output logic [15:0]                slot_id,
	output logic [mcu_pkg::data_w-1:0] slot_bridge_addr,
	output logic [mcu_pkg::data_w-1:0] slot_length,
	output logic [mcu_pkg::data_w-1:0] slot_offset,
	output logic [15:0]                slot_offset_high,

	output logic                       ext_irq,
	output logic                       timer_irq
);

	mcu_bus_if bus ();

	bus_decoder u_decoder (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.bus_req       (bus_req),
		.bus_wr        (bus_wr),
		.bus_addr      (bus_addr),
		.bus_wdata     (bus_wdata),
		.bus_rdata     (bus_rdata),
		.bus_rsp_valid (bus_rsp_valid),
		.bus           (bus.decoder)
	);

	scratch_ram u_scratch (
		.clk_sys (clk_sys),
		.bus     (bus.ram)
	);

	sys_regs u_regs (
		.clk_sys           (clk_sys),
		.reset_n           (reset_n),
		.bus               (bus.regs),
		.cont_key          (cont_key),
		.cont_joy          (cont_joy),
		.core_input        (core_input),
		.core_output       (core_output),
		.slot_read         (slot_read),
		.slot_write        (slot_write),
		.slot_flush        (slot_flush),
		.slot_get_filename (slot_get_filename),
		.slot_open_file    (slot_open_file),
		.slot_lba48        (slot_lba48),
		.slot_ack          (slot_ack),
		.slot_done         (slot_done),
		.slot_err          (slot_err),
		.slot_id           (slot_id),
		.slot_bridge_addr  (slot_bridge_addr),
		.slot_length       (slot_length),
		.slot_offset       (slot_offset),
		.slot_offset_high  (slot_offset_high),
		.ext_irq           (ext_irq),
		.timer_irq         (timer_irq)
	);

endmodule

// ==== design/ms_timer.sv ====
`timescale 1ns/1ps

module ms_timer (
	input  logic                       clk_sys,
	input  logic                       clear,
	input  logic [mcu_pkg::data_w-1:0] tick_divisor,
	input  logic [mcu_pkg::data_w-1:0] irq_threshold,
	output logic [mcu_pkg::data_w-1:0] ms_count,
	output logic [mcu_pkg::data_w-1:0] cycle_count,
	output logic                       irq
);

	logic [mcu_pkg::data_w-1:0] tick_count;
	logic                       ms_wrap;

	// One millisecond is tick_divisor + 1 cycles
	assign ms_wrap = (tick_count == tick_divisor);

	always_ff @(posedge clk_sys) begin
		if (clear) begin
			tick_count  <= '0;
			ms_count    <= '0;
			cycle_count <= '0;
			irq         <= 1'b0;
		end else begin
			cycle_count <= cycle_count + 1'b1;
			if (ms_wrap) begin
				tick_count <= '0;
				ms_count   <= ms_count + 1'b1;
				// Zero threshold means interrupt off
				if ((irq_threshold != '0) && (ms_count >= irq_threshold))
					irq <= 1'b1;   // sticky until clear
			end else begin
				tick_count <= tick_count + 1'b1;
			end
		end
	end

endmodule

// ==== design/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram (
	input  logic   clk_sys,
	mcu_bus_if.ram bus
);

	logic [mcu_pkg::data_w-1:0] mem [2**mcu_pkg::ram_addr_w];
	logic [mcu_pkg::ram_addr_w-1:0] word_idx;
	logic sel;

	assign word_idx = bus.addr[mcu_pkg::ram_addr_w+1:2];  // byte address to word
	assign sel      = bus.req && (bus.region == mcu_pkg::region_scratch);

	always_ff @(posedge clk_sys) begin
		if (sel) begin
			if (bus.wr)
				mem[word_idx] <= bus.wdata;
			else
				bus.ram_rdata <= mem[word_idx];
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_mcu_periph -o tb_mcu_periph
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mcu_periph > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "** FAIL **" "$LOG"; then
	exit 1
fi
exit 0

// ==== sys_regs/sys_regs.sv ====
`timescale 1ns/1ps

module sys_regs (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	mcu_bus_if.regs                    bus,
	input  logic [mcu_pkg::data_w-1:0] cont_key,
	input  logic [mcu_pkg::data_w-1:0] cont_joy,
	input  logic [mcu_pkg::data_w-1:0] core_input,
	output logic [mcu_pkg::data_w-1:0] core_output,
	output logic                       slot_read,
	output logic                       slot_write,
	output logic                       slot_flush,
	output logic                       slot_get_filename,
	output logic                       slot_open_file,
	output logic                       slot_lba48,
	input  logic                       slot_ack,
	input  logic                       slot_done,
	input  logic [5:0]                 slot_err,
	output logic [15:0]                slot_id,
	output logic [mcu_pkg::data_w-1:0] slot_bridge_addr,
	output logic [mcu_pkg::data_w-1:0] slot_length,
	output logic [mcu_pkg::data_w-1:0] slot_offset,
	output logic [15:0]                slot_offset_high,
	output logic                       ext_irq,
	output logic                       timer_irq
);

	logic [mcu_pkg::data_w-1:0] mailbox [8];
	logic [mcu_pkg::data_w-1:0] tick_div;
	logic [mcu_pkg::data_w-1:0] t1_thresh;
	logic [mcu_pkg::data_w-1:0] t1_count, t1_cycles;
	logic [mcu_pkg::data_w-1:0] t2_count, t2_cycles;
	logic t1_clear, t2_clear;
	logic t1_irq, t1_irq_q;
	logic timer_en, irq_mask, irq_en, done_q;
	logic reg_wr, reg_rd;
	mcu_pkg::reg_off_e off;

	assign reg_wr = bus.req && (bus.region == mcu_pkg::region_regs) && bus.wr;
	assign reg_rd = bus.req && (bus.region == mcu_pkg::region_regs) && !bus.wr;
	assign off    = mcu_pkg::reg_off_e'(bus.addr[7:0]);

	assign timer_irq = t1_irq_q && irq_mask;

	ms_timer u_timer1 (
		.clk_sys       (clk_sys),
		.clear         (t1_clear),
		.tick_divisor  (tick_div),
		.irq_threshold (t1_thresh),
		.ms_count      (t1_count),
		.cycle_count   (t1_cycles),
		.irq           (t1_irq)
	);

	ms_timer u_timer2 (
		.clk_sys       (clk_sys),
		.clear         (t2_clear),
		.tick_divisor  (tick_div),
		.irq_threshold ('0),   // timer 2 has no interrupt
		.ms_count      (t2_count),
		.cycle_count   (t2_cycles),
		.irq           ()
	);

	always_ff @(posedge clk_sys) begin
		if (reg_wr && (bus.addr[7:5] == 3'b000))
			mailbox[bus.addr[4:2]] <= bus.wdata;
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			core_output       <= '0;
			{slot_read, slot_write, slot_flush} <= '0;
			{slot_get_filename, slot_open_file, slot_lba48} <= '0;
			slot_id           <= '0;
			slot_bridge_addr  <= '0;
			slot_length       <= '0;
			slot_offset       <= '0;
			slot_offset_high  <= '0;
			ext_irq           <= 1'b0;
			irq_en            <= 1'b0;
			done_q            <= 1'b0;
			tick_div          <= '0;
			t1_thresh         <= '0;
			timer_en          <= 1'b0;
			irq_mask          <= 1'b0;
			t1_irq_q          <= 1'b0;
			t1_clear          <= 1'b1;   // Timers held clear during reset
			t2_clear          <= 1'b1;
		end else begin
			slot_read         <= 1'b0;
			slot_write        <= 1'b0;
			slot_flush        <= 1'b0;
			slot_get_filename <= 1'b0;
			slot_open_file    <= 1'b0;
			t1_clear          <= 1'b0;
			t2_clear          <= 1'b0;
			done_q            <= slot_done;
			t1_irq_q          <= t1_irq && timer_en;

			// Done edge latches the interrupt, status read acknowledges it
			if (reg_rd && (off == mcu_pkg::off_slot_cmd))
				ext_irq <= 1'b0;
			else if (slot_done && !done_q && irq_en)
				ext_irq <= 1'b1;

			if (reg_wr) begin
				case (off)
					mcu_pkg::off_core_output:      core_output <= bus.wdata;
					mcu_pkg::off_slot_id:          slot_id <= bus.wdata[15:0];
					mcu_pkg::off_bridge_addr:      slot_bridge_addr <= bus.wdata;
					mcu_pkg::off_length:           slot_length <= bus.wdata;
					mcu_pkg::off_slot_offset:      slot_offset <= bus.wdata;
					mcu_pkg::off_slot_offset_high: slot_offset_high <= bus.wdata[15:0];
					mcu_pkg::off_slot_cmd: begin
						slot_read         <= bus.wdata[mcu_pkg::slot_bit_read];
						slot_write        <= bus.wdata[mcu_pkg::slot_bit_write];
						slot_lba48        <= bus.wdata[mcu_pkg::slot_bit_lba48];
						slot_flush        <= bus.wdata[mcu_pkg::slot_bit_flush];
						slot_get_filename <= bus.wdata[mcu_pkg::slot_bit_get_filename];
						slot_open_file    <= bus.wdata[mcu_pkg::slot_bit_open_file];
						irq_en            <= bus.wdata[mcu_pkg::slot_bit_irq_en];
					end
					mcu_pkg::off_tick_div:         tick_div <= bus.wdata;
					mcu_pkg::off_timer1_count: begin
						t1_clear <= bus.wdata[0];
						timer_en <= 1'b0;       // clear also disarms
					end
					mcu_pkg::off_timer1_thresh: begin
						t1_thresh <= bus.wdata;
						timer_en  <= 1'b1;
					end
					mcu_pkg::off_timer2_count:     t2_clear <= bus.wdata[0];
					mcu_pkg::off_irq_mask:         irq_mask <= bus.wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reg_rd) begin
			case (off)
				mcu_pkg::off_mailbox0, mcu_pkg::off_mailbox1,
				mcu_pkg::off_mailbox2, mcu_pkg::off_mailbox3,
				mcu_pkg::off_mailbox4, mcu_pkg::off_mailbox5,
				mcu_pkg::off_mailbox6, mcu_pkg::off_mailbox7:
					bus.regs_rdata <= mailbox[bus.addr[4:2]];
				mcu_pkg::off_cont_key:         bus.regs_rdata <= cont_key;
				mcu_pkg::off_cont_joy:         bus.regs_rdata <= cont_joy;
				mcu_pkg::off_core_input:       bus.regs_rdata <= core_input;
				mcu_pkg::off_core_output:      bus.regs_rdata <= core_output;
				mcu_pkg::off_slot_id:          bus.regs_rdata <= {16'b0, slot_id};
				mcu_pkg::off_bridge_addr:      bus.regs_rdata <= slot_bridge_addr;
				mcu_pkg::off_length:           bus.regs_rdata <= slot_length;
				mcu_pkg::off_slot_offset:      bus.regs_rdata <= slot_offset;
				mcu_pkg::off_slot_cmd:         bus.regs_rdata <= {24'b0, slot_ack, slot_done, slot_err};
				mcu_pkg::off_tick_div:         bus.regs_rdata <= tick_div;
				mcu_pkg::off_slot_offset_high: bus.regs_rdata <= {16'b0, slot_offset_high};
				mcu_pkg::off_timer1_count:     bus.regs_rdata <= t1_count;
				mcu_pkg::off_timer1_thresh:    bus.regs_rdata <= t1_thresh;
				mcu_pkg::off_timer2_count:     bus.regs_rdata <= t2_count;
				mcu_pkg::off_irq_mask:         bus.regs_rdata <= {29'b0, t1_irq, t1_irq_q, timer_en};
				mcu_pkg::off_timer1_cycles:    bus.regs_rdata <= t1_cycles;
				mcu_pkg::off_timer2_cycles:    bus.regs_rdata <= t2_cycles;
				default:                       bus.regs_rdata <= '0;
			endcase
		end
	end

endmodule

// ==== tb.f ====
common/mcu_pkg.sv
common/mcu_bus_if.sv
design/bus_decoder.sv
design/scratch_ram.sv
design/ms_timer.sv
sys_regs/sys_regs.sv
design/mcu_periph_top.sv
verification/tb_mcu_periph.sv

// ==== verification/tb_mcu_periph.sv ====
`timescale 1ns/1ps

module tb_mcu_periph;

	localparam int op_wr = 0, op_rd = 1, op_idle = 2, op_set = 3;
	localparam int k_none = 0, k_rdata = 1, k_norsp = 2, k_save = 3, k_delta = 4;
	localparam int k_hold = 5, k_pulse = 6, k_rise = 7;
	localparam int o_core = 0, o_slot_id = 1, o_bridge = 2, o_length = 3, o_offset = 4;
	localparam int o_offset_hi = 5, o_strobes = 6, o_lba48 = 7, o_ext_irq = 8, o_timer_irq = 9;
	localparam int i_key = 0, i_joy = 1, i_core = 2, i_ack = 3, i_done = 4, i_err = 5;

	// Idle entries use addr as the cycle count and data as the watched output
	typedef struct {
		int          op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_val;
		int          kind;
		int          grp;
	} entry_t;

	logic        clk_sys, reset_n;
	logic        bus_req, bus_wr, bus_rsp_valid;
	logic [31:0] bus_addr, bus_wdata, bus_rdata;
	logic [31:0] cont_key, cont_joy, core_input, core_output;
	logic        slot_read, slot_write, slot_flush, slot_get_filename, slot_open_file;
	logic        slot_lba48, slot_ack, slot_done;
	logic [5:0]  slot_err;
	logic [15:0] slot_id, slot_offset_high;
	logic [31:0] slot_bridge_addr, slot_length, slot_offset;
	logic        ext_irq, timer_irq;

	entry_t      tbl[$];
	entry_t      pend;             // request whose response is due next cycle
	logic        pend_valid;
	logic [31:0] saved;
	logic        tbl_ready = 1'b0;
	int          cur_grp, errors, grp_errors, checks, i;
	string       grp_name[5] = '{"scratch ram", "registers", "slot command", "slot irq", "timers"};

	mcu_periph_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] reg_addr(logic [7:0] off);
		return {24'hFF_FFFF, off};
	endfunction

	function automatic logic [31:0] status_word(logic ack, logic done, logic [5:0] err);
		return {24'h0, ack, done, err};
	endfunction

	function automatic logic [31:0] observe_output(int sel);
		case (sel)
			o_core:      return core_output;
			o_slot_id:   return {16'h0, slot_id};
			o_bridge:    return slot_bridge_addr;
			o_length:    return slot_length;
			o_offset:    return slot_offset;
			o_offset_hi: return {16'h0, slot_offset_high};
			o_strobes:   return {27'h0, slot_open_file, slot_get_filename, slot_flush,
				slot_write, slot_read};
			o_lba48:     return {31'h0, slot_lba48};
			o_ext_irq:   return {31'h0, ext_irq};
			o_timer_irq: return {31'h0, timer_irq};
			default:     return 32'h0;
		endcase
	endfunction

	task automatic add_entry(int op, logic [31:0] addr, logic [31:0] data,
			logic [31:0] exp_val, int kind);
		tbl.push_back('{op, addr, data, exp_val, kind, cur_grp});
	endtask

	task automatic report_fail(string msg);
		$display("[FAIL] t=%0d ns: %s", $time, msg);
		errors++;
		grp_errors++;
	endtask

	task automatic drive_input(logic [31:0] sel, logic [31:0] val);
		case (sel)
			i_key:   cont_key   <= val;
			i_joy:   cont_joy   <= val;
			i_core:  core_input <= val;
			i_ack:   slot_ack   <= val[0];
			i_done:  slot_done  <= val[0];
			default: slot_err   <= val[5:0];
		endcase
	endtask

	// Called at each falling edge, one cycle after the pending request
	task automatic check_response();
		checks++;
		if (!pend_valid || pend.kind == k_norsp) begin
			if (bus_rsp_valid !== 1'b0)
				report_fail($sformatf("response seen with no mapped request before it"));
		end else if (bus_rsp_valid !== 1'b1) begin
			report_fail($sformatf("no response one cycle after request to %h", pend.addr));
		end else if (pend.op == op_wr) begin
			if (bus_rdata !== 32'h0)
				report_fail($sformatf("write to %h returned data %h", pend.addr, bus_rdata));
		end else if (pend.kind == k_rdata) begin
			if (bus_rdata !== pend.exp_val)
				report_fail($sformatf("read %h got %h, expected %h", pend.addr, bus_rdata,
					pend.exp_val));
		end else if (pend.kind == k_save) begin
			saved = bus_rdata;
		end else if (pend.kind == k_delta) begin
			if (bus_rdata - saved < pend.exp_val)
				report_fail($sformatf("read %h rose from %h to %h only", pend.addr, saved,
					bus_rdata));
		end
		pend_valid = 1'b0;
	endtask

	task automatic apply_entry(entry_t e);
		int          c;
		int          n_hi;
		int          first_hi;
		logic        bad;
		logic [31:0] v;
		n_hi     = 0;
		first_hi = 0;
		bad      = 1'b0;
		if (e.op == op_wr || e.op == op_rd) begin
			@(posedge clk_sys);
			bus_req   <= 1'b1;
			bus_wr    <= (e.op == op_wr);
			bus_addr  <= e.addr;
			bus_wdata <= e.data;
			@(negedge clk_sys);
			check_response();
			pend       = e;
			pend_valid = 1'b1;
		end else if (e.op == op_set) begin
			@(posedge clk_sys);
			bus_req <= 1'b0;
			drive_input(e.addr, e.data);
			@(negedge clk_sys);
			check_response();
		end else begin
			for (c = 1; c <= int'(e.addr); c++) begin
				@(posedge clk_sys);
				bus_req <= 1'b0;
				@(negedge clk_sys);
				check_response();
				v = observe_output(e.data);
				if (v != 32'h0) begin
					n_hi++;
					if (first_hi == 0)
						first_hi = c;
				end
				if (!bad && (e.kind == k_hold || (e.kind == k_pulse && v != 32'h0))
						&& v !== e.exp_val) begin
					bad = 1'b1;
					report_fail($sformatf("output %0d is %h in idle cycle %0d, expected %h",
						e.data, v, c, e.exp_val));
				end
			end
			checks++;
			// Strobe belongs in the first cycle after the command write
			if (e.kind == k_pulse && (n_hi != 1 || first_hi != 1))
				report_fail($sformatf("output %0d pulsed %0d cycles from %0d, expected 1 at 1",
					e.data, n_hi, first_hi));
			if (e.kind == k_rise && (first_hi == 0 || first_hi < int'(e.exp_val)))
				report_fail($sformatf("output %0d rose in cycle %0d, window %0d to %0d",
					e.data, first_hi, e.exp_val, e.addr));
		end
	endtask

	task automatic build_table();
		logic [31:0] v [8];
		logic [31:0] a [6];
		logic [5:0]  err;
		int          n;
		cur_grp = 0;
		for (n = 0; n < 6; n++) begin
			a[n] = {8'h01, 14'h0, 8'((($urandom % 32) * 8) + n), 2'b00};  // distinct words
			v[n] = $urandom;
			add_entry(op_wr, a[n], v[n], 0, k_none);
		end
		for (n = 0; n < 6; n++)
			add_entry(op_rd, a[n], 0, v[n], k_rdata);

		cur_grp = 1;
		for (n = 0; n < 8; n++) begin
			v[n] = $urandom;
			add_entry(op_wr, reg_addr(8'(n * 4)), v[n], 0, k_none);
		end
		for (n = 0; n < 8; n++)
			add_entry(op_rd, reg_addr(8'(n * 4)), 0, v[n], k_rdata);
		for (n = 0; n < 4; n++)
			v[n] = $urandom;
		add_entry(op_wr, reg_addr(mcu_pkg::off_core_output), v[0], 0, k_none);
		add_entry(op_rd, reg_addr(mcu_pkg::off_core_output), 0, v[0], k_rdata);
		add_entry(op_idle, 2, o_core, v[0], k_hold);
		add_entry(op_set, i_key, v[1], 0, k_none);
		add_entry(op_set, i_joy, v[2], 0, k_none);
		add_entry(op_set, i_core, v[3], 0, k_none);
		add_entry(op_rd, reg_addr(mcu_pkg::off_cont_key), 0, v[1], k_rdata);
		add_entry(op_rd, reg_addr(mcu_pkg::off_cont_joy), 0, v[2], k_rdata);
		add_entry(op_rd, reg_addr(mcu_pkg::off_core_input), 0, v[3], k_rdata);
		add_entry(op_rd, reg_addr(8'h40), 0, 0, k_rdata);    // hole in the register map
		add_entry(op_rd, 32'h2000_0000, 0, 0, k_norsp);
		add_entry(op_wr, 32'hFFFF_FE00, 0, 0, k_norsp);

		cur_grp = 2;
		for (n = 0; n < 5; n++)
			v[n] = $urandom;
		add_entry(op_wr, reg_addr(mcu_pkg::off_slot_id), v[0], 0, k_none);
		add_entry(op_idle, 1, o_slot_id, {16'h0, v[0][15:0]}, k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_bridge_addr), v[1], 0, k_none);
		add_entry(op_idle, 1, o_bridge, v[1], k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_length), v[2], 0, k_none);
		add_entry(op_idle, 1, o_length, v[2], k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_slot_offset), v[3], 0, k_none);
		add_entry(op_idle, 1, o_offset, v[3], k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_slot_offset_high), v[4], 0, k_none);
		add_entry(op_idle, 1, o_offset_hi, {16'h0, v[4][15:0]}, k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_slot_cmd), 32'h0D, 0, k_none); // read lba48 flush
		add_entry(op_idle, 4, o_strobes, 32'h05, k_pulse);
		add_entry(op_idle, 1, o_lba48, 1, k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_slot_cmd), 32'h02, 0, k_none);
		add_entry(op_idle, 4, o_strobes, 32'h02, k_pulse);
		add_entry(op_idle, 1, o_lba48, 0, k_hold);
		err = 6'($urandom);
		add_entry(op_set, i_ack, 1, 0, k_none);
		add_entry(op_set, i_err, {26'h0, err}, 0, k_none);
		add_entry(op_rd, reg_addr(mcu_pkg::off_slot_cmd), 0, status_word(1'b1, 1'b0, err), k_rdata);

		cur_grp = 3;
		add_entry(op_wr, reg_addr(mcu_pkg::off_slot_cmd), 32'h40, 0, k_none);  // enable only
		add_entry(op_idle, 3, o_ext_irq, 0, k_hold);
		add_entry(op_set, i_done, 1, 0, k_none);
		add_entry(op_idle, 5, o_ext_irq, 1, k_hold);
		add_entry(op_rd, reg_addr(mcu_pkg::off_slot_cmd), 0, status_word(1'b1, 1'b1, err), k_rdata);
		add_entry(op_idle, 3, o_ext_irq, 0, k_hold);
		add_entry(op_set, i_done, 0, 0, k_none);
		add_entry(op_wr, reg_addr(mcu_pkg::off_slot_cmd), 32'h00, 0, k_none);
		add_entry(op_set, i_done, 1, 0, k_none);
		add_entry(op_idle, 5, o_ext_irq, 0, k_hold);
		add_entry(op_set, i_done, 0, 0, k_none);

		cur_grp = 4;
		add_entry(op_wr, reg_addr(mcu_pkg::off_tick_div), 3, 0, k_none);
		add_entry(op_wr, reg_addr(mcu_pkg::off_irq_mask), 1, 0, k_none);
		add_entry(op_wr, reg_addr(mcu_pkg::off_timer1_count), 1, 0, k_none);
		add_entry(op_wr, reg_addr(mcu_pkg::off_timer1_thresh), 2, 0, k_none);
		add_entry(op_idle, 20, o_timer_irq, 8, k_rise);
		add_entry(op_wr, reg_addr(mcu_pkg::off_irq_mask), 0, 0, k_none);
		add_entry(op_idle, 6, o_timer_irq, 0, k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_irq_mask), 1, 0, k_none);
		add_entry(op_idle, 2, o_timer_irq, 1, k_hold);
		add_entry(op_wr, reg_addr(mcu_pkg::off_timer1_count), 1, 0, k_none);
		add_entry(op_idle, 1, 0, 0, k_none);      // irq flop drains one cycle later
		add_entry(op_idle, 6, o_timer_irq, 0, k_hold);
		add_entry(op_rd, reg_addr(mcu_pkg::off_timer2_count), 0, 0, k_save);
		add_entry(op_idle, 16, 0, 0, k_none);
		add_entry(op_rd, reg_addr(mcu_pkg::off_timer2_count), 0, 3, k_delta);
	endtask

	initial begin
		reset_n    = 1'b0;
		bus_req    = 1'b0;
		bus_wr     = 1'b0;
		bus_addr   = 32'h0;
		bus_wdata  = 32'h0;
		cont_key   = 32'h0;
		cont_joy   = 32'h0;
		core_input = 32'h0;
		slot_ack   = 1'b0;
		slot_done  = 1'b0;
		slot_err   = 6'h0;
		pend_valid = 1'b0;
		saved      = 32'h0;
		errors     = 0;
		grp_errors = 0;
		checks     = 0;
		void'($urandom(32'heef7));
		build_table();
		tbl_ready = 1'b1;
		repeat (5) @(posedge clk_sys);
		reset_n <= 1'b1;
		for (i = 0; i < tbl.size(); i++) begin
			apply_entry(tbl[i]);
			if (i == tbl.size() - 1 || tbl[i + 1].grp != tbl[i].grp) begin
				if (pend_valid) begin    // collect the last response of the group
					@(posedge clk_sys);
					bus_req <= 1'b0;
					@(negedge clk_sys);
					check_response();
				end
				$display("test %0d %s: %s, %0d errors", tbl[i].grp, grp_name[tbl[i].grp],
					(grp_errors == 0) ? "ok" : "FAILED", grp_errors);
				grp_errors = 0;
			end
		end
		$display("%0d tests, %0d checks, %0d errors", 5, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		wait (tbl_ready);
		repeat (tbl.size() * 200) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d cycles", tbl.size() * 200);
		$display("** FAIL **");
		$finish;
	end

endmodule
